// ==== hdl/ifetch_pkg.sv ====
/*
  Shared widths and types for the instruction-fetch subsystem.
  Import with a wildcard in the module header of every block that
  uses an address view or a cache line.
*/
package ifetch_pkg;

  // Byte address and instruction word
  localparam int ADDR_WIDTH = 32;
  localparam int WORD_WIDTH = 32;

  // Line geometry, four words of 32 bits
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_WIDTH = WORDS_PER_LINE * WORD_WIDTH;

  // Address split used by the cache
  localparam int BYTE_OFF_WIDTH = 2;
  localparam int WORD_OFF_WIDTH = $clog2(WORDS_PER_LINE);
  localparam int TAG_WIDTH = ADDR_WIDTH - WORD_OFF_WIDTH - BYTE_OFF_WIDTH;

  // One fetch address, seen either as a plain word or split into fields
  typedef union packed {
    logic [ADDR_WIDTH-1:0] raw;
    struct packed {
      logic [TAG_WIDTH-1:0] tag;
      logic [WORD_OFF_WIDTH-1:0] word_sel;
      logic [BYTE_OFF_WIDTH-1:0] byte_sel;
    } split;
  } fetch_addr_u;

  // Whole cache line, word 0 sits in the low bits
  typedef logic [LINE_WIDTH-1:0] line_t;

endpackage

// ==== hdl/fetch_unit.sv ====
/*
  Fetch unit: walks the program counter, holds a pending branch redirect
  and registers each word the cache delivers. The address stays stable
  until the cache pulses data_ready.
*/
module fetch_unit
  import ifetch_pkg::*;
#(
  parameter logic [ADDR_WIDTH-1:0] RESET_PC = '0
)
(
  input  logic clk,
  input  logic reset,
  input  logic redirect,
  input  logic [ADDR_WIDTH-1:0] redirect_target,
  input  logic data_ready,
  input  logic [WORD_WIDTH-1:0] data_out,
  output logic [ADDR_WIDTH-1:0] fetch_address,
  output logic [WORD_WIDTH-1:0] instr,
  output logic [ADDR_WIDTH-1:0] instr_address,
  output logic instr_valid
);

  // Program counter, only the raw view is needed here
  fetch_addr_u pc;

  // Redirect waiting for the next delivered word
  logic redirect_pending;
  logic [ADDR_WIDTH-1:0] pending_target;

  // A redirect in the same cycle as data_ready counts as pending
  logic take_redirect;
  logic [ADDR_WIDTH-1:0] next_target;

  assign take_redirect = redirect || redirect_pending;
  assign next_target = redirect ? redirect_target : pending_target;
  assign fetch_address = pc.raw;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pc.raw <= RESET_PC;
      redirect_pending <= 1'b0;
      instr_valid <= 1'b0;
    end
    else
    begin
      instr_valid <= 1'b0;
      if (data_ready)
      begin
        if (take_redirect)
        begin
          // Word fetched on the old path is dropped
          pc.raw <= next_target;
          redirect_pending <= 1'b0;
        end
        else
        begin
          pc.raw <= pc.raw + ADDR_WIDTH'(4);
          instr_valid <= 1'b1;
        end
      end
      else if (redirect)
      begin
        redirect_pending <= 1'b1;
      end
    end
  end

  // Target register, a later redirect overwrites the earlier one
  always_ff @(posedge clk)
  begin
    if (redirect)
      pending_target <= redirect_target;
  end

  // Output word and its address, qualified by instr_valid
  always_ff @(posedge clk)
  begin
    if (data_ready)
    begin
      instr <= data_out;
      instr_address <= pc.raw;
    end
  end

  // Cache relies on a stable address between deliveries
  a_addr_stable: assert property (@(posedge clk) disable iff (reset)
    $changed(fetch_address) |-> $past(data_ready));

endmodule

// ==== hdl/icache.sv ====
/*
  Fully associative instruction cache with true-LRU replacement.
  A lookup runs in every idle cycle with data_ready low. A miss latches
  the address, asks the line memory for the aligned line and fills the
  least recently used entry, then answers from the incoming line.
*/
module icache
  import ifetch_pkg::*;
#(
  parameter int CACHE_LINES = 4
)
(
  input  logic clk,
  input  logic reset,
  input  logic [ADDR_WIDTH-1:0] fetch_address,
  input  logic allow_op,
  input  logic mem_data_ready,
  input  line_t mem_line,
  output logic [WORD_WIDTH-1:0] data_out,
  output logic data_ready,
  output logic mem_op_init,
  output logic mem_op_done,
  output logic start_access,
  output logic [ADDR_WIDTH-1:0] mem_address
);

  localparam int LRU_W = $clog2(CACHE_LINES);

  // Fill sequence states
  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_REQ = 2'd1;
  localparam logic [1:0] S_WAIT = 2'd2;

  logic [1:0] state;

  // Line storage
  logic [TAG_WIDTH-1:0] tag_array [CACHE_LINES];
  line_t data_array [CACHE_LINES];
  logic [CACHE_LINES-1:0] valid_array;

  // Highest value is most recent, zero marks the victim
  logic [LRU_W-1:0] lru_count [CACHE_LINES];

  // Address views
  fetch_addr_u lookup_addr;
  fetch_addr_u miss_addr;

  logic [CACHE_LINES-1:0] hit_vec;
  logic hit;
  logic [LRU_W-1:0] hit_line;
  logic [LRU_W-1:0] victim;
  logic lookup_en;
  logic fill_en;
  logic touch_en;
  logic [LRU_W-1:0] touch_line;

  assign lookup_addr.raw = fetch_address;

  // Lookup only when idle and the last answer has been taken
  assign lookup_en = (state == S_IDLE) && !data_ready;
  assign fill_en = (state == S_WAIT) && mem_data_ready;

  // Tag compare against every line at once
  always_comb
  begin
    for (int i = 0; i < CACHE_LINES; i++)
      hit_vec[i] = valid_array[i] && (tag_array[i] == lookup_addr.split.tag);
  end

  assign hit = |hit_vec;

  // Lowest matching index wins
  always_comb
  begin
    hit_line = '0;
    for (int i = CACHE_LINES - 1; i >= 0; i--)
    begin
      if (hit_vec[i])
        hit_line = LRU_W'(i);
    end
  end

  // Victim is the line whose counter is zero
  always_comb
  begin
    victim = '0;
    for (int i = 0; i < CACHE_LINES; i++)
    begin
      if (lru_count[i] == '0)
        victim = LRU_W'(i);
    end
  end

  assign touch_en = (lookup_en && hit) || fill_en;
  assign touch_line = fill_en ? victim : hit_line;

  // Control path
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= S_IDLE;
      data_ready <= 1'b0;
      mem_op_init <= 1'b0;
      mem_op_done <= 1'b0;
      start_access <= 1'b0;
      valid_array <= '0;
    end
    else
    begin
      // Single-cycle pulses by default
      data_ready <= 1'b0;
      mem_op_done <= 1'b0;
      start_access <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (lookup_en)
          begin
            if (hit)
            begin
              data_ready <= 1'b1;
            end
            else
            begin
              // Ask the memory side for the line
              mem_op_init <= 1'b1;
              state <= S_REQ;
            end
          end
        end
        S_REQ:
        begin
          // Held here for as long as a load blocks the grant
          if (allow_op)
          begin
            start_access <= 1'b1;
            state <= S_WAIT;
          end
        end
        S_WAIT:
        begin
          if (mem_data_ready)
          begin
            valid_array[victim] <= 1'b1;
            data_ready <= 1'b1;
            mem_op_init <= 1'b0;
            mem_op_done <= 1'b1;
            state <= S_IDLE;
          end
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // LRU update on every hit and every fill
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < CACHE_LINES; i++)
        lru_count[i] <= LRU_W'(i);
    end
    else if (touch_en)
    begin
      for (int i = 0; i < CACHE_LINES; i++)
      begin
        if (LRU_W'(i) == touch_line)
          lru_count[i] <= LRU_W'(CACHE_LINES - 1);
        // Lines that were more recent age by one
        else if (lru_count[i] > lru_count[touch_line])
          lru_count[i] <= lru_count[i] - 1'b1;
      end
    end
  end

  // Data path, tags and line contents
  always_ff @(posedge clk)
  begin
    if (lookup_en && hit)
    begin
      data_out <= data_array[hit_line][lookup_addr.split.word_sel * WORD_WIDTH +: WORD_WIDTH];
    end
    if (lookup_en && !hit)
    begin
      miss_addr <= lookup_addr;
      mem_address <= {lookup_addr.split.tag, {(WORD_OFF_WIDTH + BYTE_OFF_WIDTH){1'b0}}};
    end
    if (fill_en)
    begin
      data_array[victim] <= mem_line;
      tag_array[victim] <= miss_addr.split.tag;
      // Answer straight from the incoming line
      data_out <= mem_line[miss_addr.split.word_sel * WORD_WIDTH +: WORD_WIDTH];
    end
  end

  // Fetch unit sees one pulse per delivered word
  a_ready_pulse: assert property (@(posedge clk) disable iff (reset)
    data_ready |=> !data_ready);

  // Memory must have granted before the access starts
  a_start_granted: assert property (@(posedge clk) disable iff (reset)
    start_access |-> allow_op);

  // Request is withdrawn when the answer goes out
  a_init_low_on_ready: assert property (@(posedge clk) disable iff (reset)
    data_ready |-> !mem_op_init);

endmodule

// ==== hdl/line_memory.sv ====
/*
  Line memory behind the instruction cache. Holds the word array with its
  load port, grants one access at a time and returns the aligned 128-bit
  line MEM_LATENCY cycles after start_access.
*/
module line_memory
  import ifetch_pkg::*;
#(
  parameter int MEM_LATENCY = 4,
  parameter int MEM_WORDS = 256
)
(
  input  logic clk,
  input  logic reset,
  input  logic load_en,
  input  logic [ADDR_WIDTH-1:0] load_addr,
  input  logic [WORD_WIDTH-1:0] load_data,
  input  logic mem_op_init,
  input  logic start_access,
  input  logic [ADDR_WIDTH-1:0] mem_address,
  input  logic mem_op_done,
  output logic allow_op,
  output logic mem_data_ready,
  output line_t mem_line
);

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

  logic [WORD_WIDTH-1:0] mem_array [MEM_WORDS];

  // Access in flight
  logic busy;
  logic [CNT_W-1:0] count;
  logic [IDX_W-1:0] line_base;
  logic [IDX_W-1:0] read_base;
  logic fire;

  // Single-cycle latency reads the address directly
  assign read_base = start_access ? {mem_address[IDX_W+1:4], 2'b00} : line_base;
  assign fire = (start_access && (MEM_LATENCY == 1)) || (busy && (count == CNT_W'(1)));

  // Load port that is also active during reset
  always_ff @(posedge clk)
  begin
    if (load_en)
      mem_array[load_addr[IDX_W+1:2]] <= load_data;
  end

  // Grant and latency counter
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      allow_op <= 1'b0;
      busy <= 1'b0;
      count <= '0;
      mem_data_ready <= 1'b0;
    end
    else
    begin
      mem_data_ready <= fire;
      // Grant held until the cache signals completion
      if (mem_op_done)
        allow_op <= 1'b0;
      else if (mem_op_init && !allow_op && !busy && !load_en)
        allow_op <= 1'b1;
      if (start_access && (MEM_LATENCY > 1))
      begin
        busy <= 1'b1;
        count <= CNT_W'(MEM_LATENCY - 1);
      end
      else if (busy)
      begin
        count <= count - 1'b1;
        if (count == CNT_W'(1))
          busy <= 1'b0;
      end
    end
  end

  // Line address and returned line
  always_ff @(posedge clk)
  begin
    if (start_access)
      line_base <= read_base;
    if (fire)
    begin
      for (int w = 0; w < WORDS_PER_LINE; w++)
        mem_line[w * WORD_WIDTH +: WORD_WIDTH] <= mem_array[read_base + IDX_W'(w)];
    end
  end

  // A line comes back exactly MEM_LATENCY cycles after its start
  a_ready_after_start: assert property (@(posedge clk) disable iff (reset)
    mem_data_ready |-> $past(start_access, MEM_LATENCY));

  // Loads may overlap an access only once the grant is out
  a_load_during_access: assert property (@(posedge clk) disable iff (reset)
    (load_en && busy) |-> allow_op);

endmodule

// ==== hdl/ifetch_top.sv ====
/*
  Instruction-fetch subsystem top level. Connects the fetch unit, the
  instruction cache and the line memory and sets their parameters.
  The load port writes words into the line memory.
*/
module ifetch_top
  import ifetch_pkg::*;
#(
  parameter logic [ADDR_WIDTH-1:0] RESET_PC = '0,
  parameter int CACHE_LINES = 4,
  parameter int MEM_LATENCY = 4,
  parameter int MEM_WORDS = 256
)
(
  input  logic clk,
  input  logic reset,
  input  logic redirect,
  input  logic [ADDR_WIDTH-1:0] redirect_target,
  input  logic load_en,
  input  logic [ADDR_WIDTH-1:0] load_addr,
  input  logic [WORD_WIDTH-1:0] load_data,
  output logic [WORD_WIDTH-1:0] instr,
  output logic [ADDR_WIDTH-1:0] instr_address,
  output logic instr_valid
);

  // Fetch unit to cache
  logic [ADDR_WIDTH-1:0] fetch_address;
  logic [WORD_WIDTH-1:0] data_out;
  logic data_ready;

  // Cache to line memory
  logic mem_op_init;
  logic mem_op_done;
  logic start_access;
  logic [ADDR_WIDTH-1:0] mem_address;
  logic allow_op;
  logic mem_data_ready;
  line_t mem_line;

  fetch_unit #(
    .RESET_PC(RESET_PC)
  ) fetch_unit_i (
    .clk(clk),
    .reset(reset),
    .redirect(redirect),
    .redirect_target(redirect_target),
    .data_ready(data_ready),
    .data_out(data_out),
    .fetch_address(fetch_address),
    .instr(instr),
    .instr_address(instr_address),
    .instr_valid(instr_valid)
  );

  icache #(
    .CACHE_LINES(CACHE_LINES)
  ) icache_i (
    .clk(clk),
    .reset(reset),
    .fetch_address(fetch_address),
    .allow_op(allow_op),
    .mem_data_ready(mem_data_ready),
    .mem_line(mem_line),
    .data_out(data_out),
    .data_ready(data_ready),
    .mem_op_init(mem_op_init),
    .mem_op_done(mem_op_done),
    .start_access(start_access),
    .mem_address(mem_address)
  );

  line_memory #(
    .MEM_LATENCY(MEM_LATENCY),
    .MEM_WORDS(MEM_WORDS)
  ) line_memory_i (
    .clk(clk),
    .reset(reset),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .mem_op_init(mem_op_init),
    .start_access(start_access),
    .mem_address(mem_address),
    .mem_op_done(mem_op_done),
    .allow_op(allow_op),
    .mem_data_ready(mem_data_ready),
    .mem_line(mem_line)
  );

endmodule

// ==== tests/ifetch_tb.sv ====
/*
  Testbench for the instruction-fetch subsystem. Loads the line memory
  through the load port during reset, then walks a table of redirects
  and checks each delivered word, its address and the gap between
  deliveries against a reference memory and an LRU model of the cache.
*/
module ifetch_tb
  import ifetch_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // Must match the DUT defaults
  localparam logic [ADDR_WIDTH-1:0] RESET_PC = '0;
  localparam int CACHE_LINES = 4;
  localparam int MEM_LATENCY = 4;
  localparam int MEM_WORDS = 256;
  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int RESET_CYCLES = 16;

  // Load burst used by the interference row
  localparam logic [ADDR_WIDTH-1:0] LOAD_BASE = 32'h0000_03e0;
  localparam int LOAD_WORDS = 8;
  localparam int ROWS = 12;

  // Target, instructions after it, hit mask with bit 0 for the first one
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] target;
    logic [7:0] count;
    logic [7:0] hit_mask;
    logic load;
  } row_t;

  logic clk = 1'b0;
  logic reset;
  logic redirect;
  logic [ADDR_WIDTH-1:0] redirect_target;
  logic load_en;
  logic [ADDR_WIDTH-1:0] load_addr;
  logic [WORD_WIDTH-1:0] load_data;
  logic [WORD_WIDTH-1:0] instr;
  logic [ADDR_WIDTH-1:0] instr_address;
  logic instr_valid;

  row_t rows [ROWS];
  string row_name [ROWS];
  logic [WORD_WIDTH-1:0] ref_mem [MEM_WORDS];
  // Cached line numbers with the least recent at the front
  logic [ADDR_WIDTH-1:0] lru_q [$];

  int seed = 32'hd15;
  int cycle = 0;
  int limit;
  int last_cycle;
  int load_left = 0;
  logic [ADDR_WIDTH-1:0] load_next;
  int row_errs = 0;
  int pass_count = 0;
  int fail_count = 0;

  ifetch_top ifetch_top_i (
    .clk(clk),
    .reset(reset),
    .redirect(redirect),
    .redirect_target(redirect_target),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .instr(instr),
    .instr_address(instr_address),
    .instr_valid(instr_valid)
  );

  always #2 clk = ~clk;

  // Cycle count and run limit
  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= limit)
    begin
      $display("timeout: no instr_valid pulse arrived within %0d cycles", limit);
      $display("Test FAILED");
      $finish;
    end
  end

  // One falling edge ends the redirect pulse and drives the next load word
  task automatic advance_cycle();
    @(negedge clk);
    redirect = 1'b0;
    if (load_left > 0)
    begin
      load_en = 1'b1;
      load_addr = load_next;
      load_data = $random(seed);
      ref_mem[load_next[IDX_W+1:2]] = load_data;
      load_next = load_next + 4;
      load_left = load_left - 1;
    end
    else
    begin
      load_en = 1'b0;
    end
  endtask

  // Cycles since the previous delivery
  task automatic wait_instr(output int gap);
    do
    begin
      advance_cycle();
    end while (!instr_valid);
    gap = cycle - last_cycle;
    last_cycle = cycle;
  endtask

  // Touches one line in the model and returns 1 on a hit
  function automatic bit lru_access(input logic [ADDR_WIDTH-1:0] addr);
    logic [ADDR_WIDTH-1:0] line;
    bit found;
    line = addr >> (WORD_OFF_WIDTH + BYTE_OFF_WIDTH);
    found = 1'b0;
    for (int k = 0; k < lru_q.size(); k++)
    begin
      if (lru_q[k] == line)
      begin
        lru_q.delete(k);
        found = 1'b1;
        break;
      end
    end
    if (!found && lru_q.size() == CACHE_LINES)
      void'(lru_q.pop_front());
    lru_q.push_back(line);
    return found;
  endfunction

  // Cycles one fetch takes from the previous delivery
  function automatic int fetch_cost(input bit hit);
    if (hit)
      return 2;
    else
      return MEM_LATENCY + 5;
  endfunction

  initial
  begin
    int gap;
    int exp_gap;
    int extra_gap;
    int total;
    bit hit;
    logic [ADDR_WIDTH-1:0] next_pc;

    // Straight run over two lines and a jump back into cached lines
    rows[0] = '{RESET_PC, 8'd8, 8'hee, 1'b0};
    rows[1] = '{32'h0000_0008, 8'd3, 8'h07, 1'b0};
    // Lines A to E and A again after its eviction
    rows[2] = '{32'h0000_0080, 8'd1, 8'h00, 1'b0};
    rows[3] = '{32'h0000_0090, 8'd1, 8'h00, 1'b0};
    rows[4] = '{32'h0000_00a0, 8'd1, 8'h00, 1'b0};
    rows[5] = '{32'h0000_00b0, 8'd1, 8'h00, 1'b0};
    rows[6] = '{32'h0000_00c0, 8'd1, 8'h00, 1'b0};
    rows[7] = '{32'h0000_0080, 8'd1, 8'h00, 1'b0};
    rows[8] = '{32'h0000_00c4, 8'd1, 8'h01, 1'b0};
    rows[9] = '{32'h0000_00a8, 8'd1, 8'h01, 1'b0};
    // Load burst during a miss and a fetch of the loaded words
    rows[10] = '{32'h0000_0040, 8'd2, 8'h02, 1'b1};
    rows[11] = '{LOAD_BASE, 8'd8, 8'hee, 1'b0};
    row_name[0] = "reset_straight_run";
    row_name[1] = "jump_back_cached";
    row_name[2] = "line_a";
    row_name[3] = "line_b";
    row_name[4] = "line_c";
    row_name[5] = "line_d";
    row_name[6] = "line_e";
    row_name[7] = "return_to_a";
    row_name[8] = "line_e_kept";
    row_name[9] = "line_c_kept";
    row_name[10] = "load_during_miss";
    row_name[11] = "fetch_loaded_words";

    // Memory load plus every fetch of the table including the dropped ones
    total = 0;
    for (int r = 0; r < ROWS; r++)
      total += int'(rows[r].count);
    limit = MEM_WORDS + (total + ROWS) * (MEM_LATENCY + 5) + 200;

    reset = 1'b1;
    redirect = 1'b0;
    redirect_target = '0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    extra_gap = 0;
    next_pc = RESET_PC;

    // Whole memory loaded from the start of reset
    load_left = MEM_WORDS;
    load_next = '0;
    for (int n = 0; n < MEM_WORDS; n++)
    begin
      advance_cycle();
      if (reset && instr_valid !== 1'b0)
      begin
        $display("instr_valid went high during reset");
        row_errs++;
      end
      if (n == RESET_CYCLES - 1)
        reset = 1'b0;
    end
    advance_cycle();
    last_cycle = cycle;

    for (int r = 0; r < ROWS; r++)
    begin
      if (r > 0)
      begin
        // The word at next_pc is still fetched and then dropped
        redirect = 1'b1;
        redirect_target = rows[r].target;
        extra_gap = fetch_cost(lru_access(next_pc));
        next_pc = rows[r].target;
        if (rows[r].load)
        begin
          load_left = LOAD_WORDS;
          load_next = LOAD_BASE;
        end
      end
      for (int i = 0; i < int'(rows[r].count); i++)
      begin
        wait_instr(gap);
        hit = lru_access(next_pc);
        if (hit != rows[r].hit_mask[i])
        begin
          $display("%s: hit pattern of instruction %0d does not match the LRU model",
                   row_name[r], i);
          row_errs++;
        end
        if (i > 0)
          exp_gap = fetch_cost(hit);
        else if (r == 0)
          // Counted from the end of the load since the grant comes one edge later
          exp_gap = MEM_LATENCY + 4;
        else
          exp_gap = extra_gap + fetch_cost(hit);
        if (instr_address !== next_pc)
        begin
          $display("** Error: instr_address = %h, expected %h", instr_address, next_pc);
          row_errs++;
        end
        if (instr !== ref_mem[next_pc[IDX_W+1:2]])
        begin
          $display("** Error: instr = %h, expected %h", instr, ref_mem[next_pc[IDX_W+1:2]]);
          row_errs++;
        end
        // A load holding off the grant only stretches the gap
        if (rows[r].load && i == 0)
        begin
          if (gap <= exp_gap)
          begin
            $display("** Error: gap = %h, expected above %h", gap, exp_gap);
            row_errs++;
          end
        end
        else if (gap != exp_gap)
        begin
          $display("** Error: gap = %h, expected %h", gap, exp_gap);
          row_errs++;
        end
        next_pc = next_pc + 4;
      end
      if (row_errs == 0)
      begin
        $display("%s: passed", row_name[r]);
        pass_count++;
      end
      else
      begin
        $display("%s: failed with %0d errors", row_name[r], row_errs);
        fail_count++;
      end
      row_errs = 0;
    end

    $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// ==== list.f ====
hdl/ifetch_pkg.sv
hdl/fetch_unit.sv
hdl/icache.sv
hdl/line_memory.sv
hdl/ifetch_top.sv
tests/ifetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the instruction-fetch testbench with Verilator and runs it.
# The result is taken from the simulation log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal \
  -f list.f --top-module ifetch_tb -o ifetch_sim

./obj_dir/ifetch_sim | tee sim.log

if grep -qx "Test OK" sim.log
then
  echo "simulation passed"
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi
